//--- Makefile
TOP := icache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f icache.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps +incdir+common \
		common/icache_pkg.sv icache/icache_store.sv icache/icache_refill.sv \
		icache/icache_ctrl.sv hdl/icache_top.sv --top-module icache_top

clean:
	rm -rf obj_dir

//--- common/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Cache geometry

// Number of sets
`define ICACHE_NUM_SETS 8

// Associativity
`define ICACHE_NUM_WAYS 4

// 32-bit words per line
`define ICACHE_BLOCK_WORDS 4

// Byte address width on core and memory side
`define ICACHE_ADDR_W 32

`endif

//--- common/icache_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    localparam int SET_BITS  = $clog2(`ICACHE_NUM_SETS);
    localparam int WAY_BITS  = $clog2(`ICACHE_NUM_WAYS);
    localparam int OFF_BITS  = $clog2(`ICACHE_BLOCK_WORDS);
    // Two byte-select bits below the word offset
    localparam int TAG_BITS  = `ICACHE_ADDR_W - SET_BITS - OFF_BITS - 2;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [31:0]               word_t;
    typedef logic [SET_BITS-1:0]       set_idx_t;
    typedef logic [WAY_BITS-1:0]       way_t;
    typedef logic [OFF_BITS-1:0]       word_off_t;
    typedef logic [TAG_BITS-1:0]       tag_t;

    // Whole cache line, word 0 in the low bits
    typedef word_t [`ICACHE_BLOCK_WORDS-1:0] line_t;

    // Address split, MSB first
    typedef struct packed {
        tag_t      tag;
        set_idx_t  set_idx;
        word_off_t word_off;
        logic [1:0] byte_off;
    } fetch_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        RESPOND
    } cache_state_e;

endpackage

`default_nettype wire

//--- dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam logic [16:0] SEED        = 17'd79197;
    localparam int          LINE_BYTES  = `ICACHE_BLOCK_WORDS * 4;
    // Directed plus random fetches
    localparam int          NUM_FETCHES = 320;
    // Request, four words with three idle cycles each, response, idle checks
    localparam int          MISS_CYCLES = 30;
    localparam int          MAX_CYCLES  = NUM_FETCHES * MISS_CYCLES + 200;

    logic  Clk;
    logic  arst_n;
    logic  read_en;
    addr_t read_addr;
    word_t instruction;
    logic  ready;
    logic  busy;
    addr_t mem_read_addr;
    logic  mem_read_req;
    word_t mem_data_in;
    logic  mem_data_ready;

    // Scoreboard copy of tags, valid bits and round-robin pointers
    tag_t                        m_tag   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    logic [`ICACHE_NUM_WAYS-1:0] m_valid [`ICACHE_NUM_SETS];
    way_t                        m_ptr   [`ICACHE_NUM_SETS];

    addr_t       cur_addr;
    int          fetch_count;
    int          resp_count;
    int          req_count;
    int          cycles;
    logic [16:0] stim_lfsr;
    logic [16:0] mem_lfsr;
    addr_t       mem_base;
    int unsigned gap;
    int unsigned rnd_word;
    int unsigned rnd_poke;

    icache_top i_icache_top (.*);

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Fibonacci LFSR, taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_bits(inout logic [16:0] s, input int n, output int unsigned v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = (v << 1) | {31'd0, s[0]};
        end
    endtask

    // Memory contents: word address mixed with a constant
    function automatic word_t mem_word(input addr_t a);
        word_t w;
        w = word_t'(a & ~addr_t'(3));
        return (w * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    // Predict hit or miss, and on a miss apply the replacement rule
    function automatic logic model_access(input addr_t a);
        fetch_addr_t f;
        logic        found;
        logic        free_way;
        way_t        v;
        f        = fetch_addr_t'(a);
        found    = 1'b0;
        free_way = 1'b0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (m_valid[f.set_idx][w] && (m_tag[f.set_idx][w] == f.tag)) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            v = m_ptr[f.set_idx];
            for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
                if (!free_way && !m_valid[f.set_idx][w]) begin
                    v        = way_t'(w);
                    free_way = 1'b1;
                end
            end
            if (!free_way) begin
                m_ptr[f.set_idx] = m_ptr[f.set_idx] + way_t'(1);
            end
            m_valid[f.set_idx][v] = 1'b1;
            m_tag[f.set_idx][v]   = f.tag;
        end
        return found;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, msg, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, msg, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, msg, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // One fetch; with poke set, strobe again while a miss is outstanding
    task automatic fetch(input addr_t a, input logic poke);
        logic exp_hit;
        logic poked;
        int   edges;
        int   reqs_before;
        exp_hit     = model_access(a);
        reqs_before = req_count;
        poked       = 1'b0;
        edges       = 0;
        @(posedge Clk);
        cur_addr    = a;
        fetch_count = fetch_count + 1;
        read_en     <= 1'b1;
        read_addr   <= a;
        do begin
            @(posedge Clk);
            edges++;
            if (poke && !poked && (req_count != reqs_before)) begin
                read_en   <= 1'b1;
                read_addr <= a ^ 32'h0000_0800;
                poked     = 1'b1;
            end else begin
                read_en <= 1'b0;
            end
            @(negedge Clk);
            if (!ready) begin
                check_bit(busy, 1'b1, "busy while the fetch is outstanding");
            end
        end while (!ready);
        check_bit(busy, 1'b0, "busy in the ready cycle");
        check_bit(req_count != reqs_before, !exp_hit, "memory request on miss");
        check_bit(req_count - reqs_before <= 1, 1'b1, "one memory request per miss");
        if (exp_hit) begin
            check_bit(edges == 2, 1'b1, "ready two edges after a hit strobe");
        end
        if (poked) begin
            repeat (4) begin
                @(negedge Clk);
                check_bit(ready | busy, 1'b0, "activity after strobe while busy");
            end
        end
    endtask

    // Compare process for responses and memory requests
    initial begin
        resp_count = 0;
        req_count  = 0;
        forever begin
            @(negedge Clk);
            if ((ready || mem_read_req) && (resp_count == fetch_count)) begin
                $display("Response or memory request seen with no fetch outstanding");
                $display(">>> FAIL");
                $fatal(1);
            end else begin
                if (mem_read_req) begin
                    req_count++;
                    check_addr(mem_read_addr, cur_addr & ~addr_t'(LINE_BYTES - 1),
                               "memory line address");
                end
                if (ready) begin
                    check_word(instruction, mem_word(cur_addr), "instruction");
                    resp_count++;
                end
            end
        end
    end

    // SDRAM model, 0 to 3 idle cycles before each word
    initial begin
        mem_lfsr       = SEED;
        mem_data_ready = 1'b0;
        mem_data_in    = '0;
        forever begin
            @(negedge Clk);
            if (mem_read_req) begin
                mem_base = mem_read_addr;
                for (int w = 0; w < `ICACHE_BLOCK_WORDS; w++) begin
                    draw_bits(mem_lfsr, 2, gap);
                    repeat (gap) begin
                        @(posedge Clk);
                        mem_data_ready <= 1'b0;
                    end
                    @(posedge Clk);
                    mem_data_ready <= 1'b1;
                    mem_data_in    <= mem_word(mem_base + addr_t'(4 * w));
                end
                @(posedge Clk);
                mem_data_ready <= 1'b0;
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge Clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
                $display(">>> FAIL");
                $fatal(1);
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        read_en     = 1'b0;
        read_addr   = '0;
        cur_addr    = '0;
        fetch_count = 0;
        stim_lfsr   = SEED;
        for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
            m_valid[s] = '0;
            m_ptr[s]   = '0;
        end
        repeat (10) @(posedge Clk);
        arst_n <= 1'b1;
        repeat (3) begin
            @(negedge Clk);
            check_bit(ready | busy | mem_read_req, 1'b0, "outputs idle after reset");
        end
        // Cold miss, then the rest of the line hits
        fetch(32'h0000_1008, 1'b0);
        fetch(32'h0000_1000, 1'b0);
        fetch(32'h0000_1004, 1'b0);
        fetch(32'h0000_100C, 1'b0);
        // Six lines in set 4, then refetch across the two evictions
        for (int k = 0; k < 6; k++) begin
            fetch(32'h0000_2040 + addr_t'(k * 128), 1'b0);
        end
        for (int k = 2; k < 8; k++) begin
            fetch(32'h0000_2040 + addr_t'((k % 6) * 128 + 4), 1'b0);
        end
        fetch(32'h0000_3000, 1'b1);
        fetch(32'h0000_3004, 1'b0);
        // Random stream over 64 lines
        for (int i = 0; i < 300; i++) begin
            draw_bits(stim_lfsr, 8, rnd_word);
            draw_bits(stim_lfsr, 2, rnd_poke);
            fetch(32'h0000_4000 + addr_t'(rnd_word << 2), rnd_poke == 0);
        end
        repeat (4) @(negedge Clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic  Clk,
    input  logic  arst_n,
    input  logic  read_en,
    input  addr_t read_addr,
    output word_t instruction,
    output logic  ready,
    output logic  busy,
    output addr_t mem_read_addr,
    output logic  mem_read_req,
    input  word_t mem_data_in,
    input  logic  mem_data_ready
);

    fetch_addr_t lookup_addr;
    logic        hit;
    word_t       hit_word;
    logic        fill_en;
    logic        refill_start;
    logic        line_done;
    line_t       fill_line;

    // Fetch side
    icache_ctrl i_icache_ctrl (
        .Clk           (Clk),
        .arst_n        (arst_n),
        .read_en       (read_en),
        .read_addr     (read_addr),
        .instruction   (instruction),
        .ready         (ready),
        .busy          (busy),
        .mem_read_addr (mem_read_addr),
        .mem_read_req  (mem_read_req),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .hit_word      (hit_word),
        .fill_en       (fill_en),
        .refill_start  (refill_start),
        .line_done     (line_done),
        .fill_line     (fill_line)
    );

    icache_store i_icache_store (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_word    (hit_word),
        .fill_en     (fill_en),
        .fill_line   (fill_line)
    );

    // Memory side
    icache_refill i_icache_refill (
        .Clk            (Clk),
        .arst_n         (arst_n),
        .refill_start   (refill_start),
        .mem_data_in    (mem_data_in),
        .mem_data_ready (mem_data_ready),
        .line_done      (line_done),
        .fill_line      (fill_line)
    );

endmodule

`default_nettype wire

//--- icache.f
+incdir+common
common/icache_pkg.sv
icache/icache_store.sv
icache/icache_refill.sv
icache/icache_ctrl.sv
hdl/icache_top.sv
dv/icache_tb.sv

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  logic        Clk,
    input  logic        arst_n,
    input  logic        read_en,
    input  addr_t       read_addr,
    output word_t       instruction,
    output logic        ready,
    output logic        busy,
    output addr_t       mem_read_addr,
    output logic        mem_read_req,
    output fetch_addr_t lookup_addr,
    input  logic        hit,
    input  word_t       hit_word,
    output logic        fill_en,
    output logic        refill_start,
    input  logic        line_done,
    input  line_t       fill_line
);

    cache_state_e state;
    fetch_addr_t  line_addr;
    logic         accept;
    logic         miss;

    // New fetches only while not busy
    assign accept = read_en && !busy;
    assign miss   = (state == LOOKUP) && !hit;

    // Commit in the line_done cycle
    assign fill_en = (state == MISS_WAIT) && line_done;

    always_comb begin
        line_addr          = lookup_addr;
        line_addr.word_off = '0;
        line_addr.byte_off = '0;
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            ready        <= 1'b0;
            busy         <= 1'b0;
            mem_read_req <= 1'b0;
            refill_start <= 1'b0;
        end else begin
            ready        <= 1'b0;
            mem_read_req <= 1'b0;
            refill_start <= 1'b0;
            case (state)
                IDLE, RESPOND: begin
                    if (accept) begin
                        busy  <= 1'b1;
                        state <= LOOKUP;
                    end else begin
                        state <= IDLE;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        ready <= 1'b1;
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else begin
                        mem_read_req <= 1'b1;
                        refill_start <= 1'b1;
                        state        <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (line_done) begin
                        ready <= 1'b1;
                        busy  <= 1'b0;
                        state <= RESPOND;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data payload
    always_ff @(posedge Clk) begin
        if (accept) begin
            lookup_addr <= fetch_addr_t'(read_addr);
        end
        if (miss) begin
            mem_read_addr <= addr_t'(line_addr);
        end
        if ((state == LOOKUP) && hit) begin
            instruction <= hit_word;
        end else if (fill_en) begin
            instruction <= fill_line[lookup_addr.word_off];
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic  Clk,
    input  logic  arst_n,
    input  logic  refill_start,
    input  word_t mem_data_in,
    input  logic  mem_data_ready,
    output logic  line_done,
    output line_t fill_line
);

    localparam word_off_t LAST_WORD = word_off_t'(`ICACHE_BLOCK_WORDS - 1);

    word_off_t word_cnt;
    logic      active;
    logic      take_word;

    // Strobes outside a refill are dropped
    assign take_word = active && mem_data_ready;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt  <= '0;
            active    <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (refill_start) begin
                word_cnt <= '0;
                active   <= 1'b1;
            end else if (take_word) begin
                word_cnt <= word_cnt + word_off_t'(1);
                if (word_cnt == LAST_WORD) begin
                    active    <= 1'b0;
                    line_done <= 1'b1;
                end
            end
        end
    end

    // Line buffer, held until the next refill overwrites it
    always_ff @(posedge Clk) begin
        if (take_word) begin
            fill_line[word_cnt] <= mem_data_in;
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_store
    import icache_pkg::*;
(
    input  logic        Clk,
    input  logic        arst_n,
    input  fetch_addr_t lookup_addr,
    output logic        hit,
    output word_t       hit_word,
    input  logic        fill_en,
    input  line_t       fill_line
);

    // Arrays, indexed [set][way]
    tag_t  tags   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    line_t data   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    logic [`ICACHE_NUM_WAYS-1:0] valid [`ICACHE_NUM_SETS];
    way_t  rr_ptr [`ICACHE_NUM_SETS];

    set_idx_t set_idx;
    way_t     hit_way;
    way_t     victim_way;
    logic     set_full;

    assign set_idx  = lookup_addr.set_idx;
    assign set_full = &valid[set_idx];

    // Parallel tag compare over all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (valid[set_idx][w] && (tags[set_idx][w] == lookup_addr.tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_word = data[set_idx][hit_way][lookup_addr.word_off];

    // Lowest invalid way wins, else the round-robin pointer
    always_comb begin
        victim_way = rr_ptr[set_idx];
        for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[set_idx][w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    // Control state: valid bits and pointers
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (fill_en) begin
            valid[set_idx][victim_way] <= 1'b1;
            // Pointer only moves when it picked the victim
            if (set_full) begin
                rr_ptr[set_idx] <= rr_ptr[set_idx] + way_t'(1);
            end
        end
    end

    // Tag and data payload
    always_ff @(posedge Clk) begin
        if (fill_en) begin
            tags[set_idx][victim_way] <= lookup_addr.tag;
            data[set_idx][victim_way] <= fill_line;
        end
    end

endmodule

`default_nettype wire
